// ==== periph_pkg.sv ====
package periph_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and counts

    localparam int data_w    = 32;
    localparam int n_lanes   = data_w / 8;
    localparam int cnt_w     = 64;
    localparam int reg_idx_w = 4;
    localparam int n_ext_irq = 8;
    localparam int n_irq     = n_ext_irq + 1;
    localparam int irq_num_w = 4;

    // register map, word index from adr[5:2]
    localparam logic [reg_idx_w-1:0] reg_gpio_data   = 4'd0;
    localparam logic [reg_idx_w-1:0] reg_gpio_dir    = 4'd1;
    localparam logic [reg_idx_w-1:0] reg_counter_lo  = 4'd2;
    localparam logic [reg_idx_w-1:0] reg_counter_hi  = 4'd3;
    localparam logic [reg_idx_w-1:0] reg_irq_ctrl    = 4'd4;
    localparam logic [reg_idx_w-1:0] reg_timer_ie    = 4'd5;
    localparam logic [reg_idx_w-1:0] reg_timer_if    = 4'd6;
    localparam logic [reg_idx_w-1:0] reg_timer_value = 4'd7;
    localparam logic [reg_idx_w-1:0] reg_timer_max   = 4'd8;
    localparam logic [reg_idx_w-1:0] reg_irq_number  = 4'd9;

    //////////////////////////////////////////////////////////////////////
    // bus and status types

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [reg_idx_w-1:0] adr;
        logic [n_lanes-1:0]   sel;
        logic [data_w-1:0]    wdata;
    } bus_req_s;

    typedef struct packed {
        logic               gpio_data;
        logic               gpio_dir;
        logic               counter_cmd;
        logic               irq_ctrl;
        logic               timer_ie;
        logic               timer_if_cmd;
        logic               timer_max;
        logic [n_lanes-1:0] lanes;
    } reg_wr_s;

    typedef struct packed {
        logic [data_w-3:0] rsvd;
        logic              clear;
        logic              sample;
    } counter_cmd_s;

    typedef struct packed {
        logic [data_w-3:0] rsvd;
        logic              reload;
        logic              flag_clr;
    } timer_cmd_s;

    // one write word, read per target register
    typedef union packed {
        logic [data_w-1:0] word;
        counter_cmd_s      counter;
        timer_cmd_s        timer;
    } cmd_word_u;

    typedef struct packed {
        logic [cnt_w-1:0]  counter_sample;
        logic [data_w-1:0] value;
        logic [data_w-1:0] max;
        logic              flag;
        logic              enable;
    } timer_stat_s;

    typedef struct packed {
        logic                 in_service;
        logic [irq_num_w-1:0] number;
    } irq_stat_s;

    // byte lane merge for the byte writable registers
    function automatic logic [data_w-1:0] merge_bytes(
        input logic [data_w-1:0]  old_word,
        input logic [data_w-1:0]  new_word,
        input logic [n_lanes-1:0] lanes
    );
        logic [data_w-1:0] result;
        result = old_word;
        for (int b = 0; b < n_lanes; b++) begin
            if (lanes[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

// ==== periph_bus.sv ====
`timescale 1ns/100ps

module periph_bus (
    input  logic                          clk,
    input  logic                          rst,
    input  periph_pkg::bus_req_s          req,
    output periph_pkg::reg_wr_s           wr,
    output logic [periph_pkg::data_w-1:0] wdata,
    input  periph_pkg::timer_stat_s       tstat,
    input  logic [periph_pkg::data_w-1:0] gpio_data,
    input  logic [periph_pkg::data_w-1:0] gpio_dir,
    input  periph_pkg::irq_stat_s         istat,
    output logic [periph_pkg::data_w-1:0] rdata,
    output logic                          ack
);

    logic                          valid;
    logic                          wr_en;
    logic                          rd_en;
    logic                          ack_q;
    logic [periph_pkg::data_w-1:0] rd_word;

    assign valid = req.cyc & req.stb;
    assign wr_en = valid & req.we;
    assign rd_en = valid & ~req.we;
    assign wdata = req.wdata;

    //////////////////////////////////////////////////////////////////////
    // write decode

    always_comb begin
        wr = '0;
        wr.lanes = req.sel;
        if (wr_en) begin
            case (req.adr)
                periph_pkg::reg_gpio_data: wr.gpio_data = 1'b1;
                periph_pkg::reg_gpio_dir:  wr.gpio_dir = 1'b1;
                periph_pkg::reg_timer_max: wr.timer_max = 1'b1;
                // narrow registers and commands live in lane 0
                periph_pkg::reg_counter_lo: wr.counter_cmd = req.sel[0];
                periph_pkg::reg_irq_ctrl:   wr.irq_ctrl = req.sel[0];
                periph_pkg::reg_timer_ie:   wr.timer_ie = req.sel[0];
                periph_pkg::reg_timer_if:   wr.timer_if_cmd = req.sel[0];
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read select

    always_comb begin
        case (req.adr)
            periph_pkg::reg_gpio_data: rd_word = gpio_data;
            periph_pkg::reg_gpio_dir:  rd_word = gpio_dir;
            periph_pkg::reg_counter_lo: begin
                rd_word = tstat.counter_sample[periph_pkg::data_w-1:0];
            end
            periph_pkg::reg_counter_hi: begin
                rd_word = tstat.counter_sample[periph_pkg::cnt_w-1:periph_pkg::data_w];
            end
            periph_pkg::reg_irq_ctrl: begin
                rd_word = {{(periph_pkg::data_w-1){1'b0}}, istat.in_service};
            end
            periph_pkg::reg_timer_ie: begin
                rd_word = {{(periph_pkg::data_w-1){1'b0}}, tstat.enable};
            end
            periph_pkg::reg_timer_if: begin
                rd_word = {{(periph_pkg::data_w-1){1'b0}}, tstat.flag};
            end
            periph_pkg::reg_timer_value: rd_word = tstat.value;
            periph_pkg::reg_timer_max:   rd_word = tstat.max;
            periph_pkg::reg_irq_number: begin
                // number as a word offset into a vector table
                rd_word = periph_pkg::data_w'(istat.number) << 2;
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req.stb;
        end
    end

    // read word holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_word;
        end
    end

    assign ack = req.cyc & ack_q;

endmodule

// ==== sys_timer.sv ====
`timescale 1ns/100ps

module sys_timer (
    input  logic                          clk,
    input  logic                          rst,
    input  periph_pkg::reg_wr_s           wr,
    input  logic [periph_pkg::data_w-1:0] wdata,
    output periph_pkg::timer_stat_s       tstat,
    output logic                          timer_irq
);

    periph_pkg::cmd_word_u          cmd;
    logic [periph_pkg::cnt_w-1:0]   counter;
    logic [periph_pkg::cnt_w-1:0]   sample;
    logic [periph_pkg::data_w-1:0]  value;
    logic [periph_pkg::data_w-1:0]  max_q;
    logic                           flag;
    logic                           enable;
    logic                           expired;

    assign cmd = wdata;
    assign expired = (value == '0);

    //////////////////////////////////////////////////////////////////////
    // free running cycle counter

    always_ff @(posedge clk) begin
        if (rst) begin
            counter <= '0;
            sample <= '0;
        end else if (wr.counter_cmd && cmd.counter.clear) begin
            counter <= '0;
            sample <= '0;
        end else begin
            counter <= counter + 1'b1;
            if (wr.counter_cmd && cmd.counter.sample) begin
                sample <= counter;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reloading down timer

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
            max_q <= '0;
            flag <= 1'b0;
            enable <= 1'b0;
        end else begin
            if (wr.timer_max) begin
                max_q <= periph_pkg::merge_bytes(max_q, wdata, wr.lanes);
            end
            if (wr.timer_ie) begin
                enable <= wdata[0];
            end
            if ((wr.timer_if_cmd && cmd.timer.reload) || expired) begin
                value <= max_q;
            end else begin
                value <= value - 1'b1;
            end
            // clear command beats a same cycle expiry
            if (wr.timer_if_cmd && cmd.timer.flag_clr) begin
                flag <= 1'b0;
            end else if (expired) begin
                flag <= 1'b1;
            end
        end
    end

    assign timer_irq = flag & enable;

    assign tstat = '{
        counter_sample: sample,
        value:          value,
        max:            max_q,
        flag:           flag,
        enable:         enable
    };

endmodule

// ==== gpio_port.sv ====
`timescale 1ns/100ps

module gpio_port (
    input  logic                          clk,
    input  logic                          rst,
    input  periph_pkg::reg_wr_s           wr,
    input  logic [periph_pkg::data_w-1:0] wdata,
    input  logic [periph_pkg::data_w-1:0] gpio_in,
    output logic [periph_pkg::data_w-1:0] gpio_out,
    output logic [periph_pkg::data_w-1:0] gpio_dir,
    output logic [periph_pkg::data_w-1:0] data,
    output logic [periph_pkg::data_w-1:0] dir_reg
);

    logic [periph_pkg::data_w-1:0] data_q;
    logic [periph_pkg::data_w-1:0] data_wr;
    logic [periph_pkg::data_w-1:0] dir_q;
    logic [periph_pkg::data_w-1:0] dir_s1;
    logic [periph_pkg::data_w-1:0] in_s;
    logic [periph_pkg::data_w-1:0] out_s;

    assign data_wr = wr.gpio_data ? periph_pkg::merge_bytes(data_q, wdata, wr.lanes) : data_q;

    // dir bit 1 = input
    always_ff @(posedge clk) begin
        if (rst) begin
            data_q <= '0;
            dir_q <= '0;
            dir_s1 <= '0;
            in_s <= '0;
            out_s <= '0;
            gpio_dir <= '0;
            gpio_out <= '0;
        end else begin
            if (wr.gpio_dir) begin
                dir_q <= periph_pkg::merge_bytes(dir_q, wdata, wr.lanes);
            end
            dir_s1 <= dir_q;
            gpio_dir <= dir_s1;
            in_s <= gpio_in;
            out_s <= data_q;
            data_q <= (dir_q & in_s) | (~dir_q & data_wr);
            gpio_out <= (dir_q & gpio_out) | (~dir_q & out_s);
        end
    end

    assign data = data_q;
    assign dir_reg = dir_q;

endmodule

// ==== irq_controller.sv ====
`timescale 1ns/100ps

module irq_controller (
    input  logic                             clk,
    input  logic                             rst,
    input  periph_pkg::reg_wr_s              wr,
    input  logic [periph_pkg::data_w-1:0]    wdata,
    input  logic [periph_pkg::n_ext_irq-1:0] ext_irq,
    input  logic                             timer_irq,
    input  logic                             irq_ack,
    input  logic                             irq_exit,
    output logic                             cpu_irq,
    output periph_pkg::irq_stat_s            istat
);

    logic [periph_pkg::n_irq-1:0]     sources;
    logic [periph_pkg::irq_num_w-1:0] pick;
    logic [periph_pkg::irq_num_w-1:0] number;
    logic                             pending;
    logic                             req_q;
    logic                             in_service;

    // timer sits above the external lines
    assign sources = {timer_irq, ext_irq};

    // highest numbered active source wins
    always_comb begin
        pending = 1'b0;
        pick = '0;
        for (int i = 0; i < periph_pkg::n_irq; i++) begin
            if (sources[i]) begin
                pending = 1'b1;
                pick = periph_pkg::irq_num_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
            number <= '0;
            in_service <= 1'b0;
        end else begin
            if (irq_ack) begin
                req_q <= 1'b0;
                in_service <= 1'b1;
            end else if (!req_q && !in_service && pending) begin
                req_q <= 1'b1;
                number <= pick;
            end
            if (irq_exit) begin
                in_service <= 1'b0;
            end
            // software write has the last word
            if (wr.irq_ctrl) begin
                in_service <= wdata[0];
            end
        end
    end

    assign cpu_irq = req_q & ~in_service & sources[number];

    assign istat = '{in_service: in_service, number: number};

endmodule

// ==== periph_top.sv ====
`timescale 1ns/100ps

module periph_top (
    input  logic                             clk,
    input  logic                             rst,
    input  periph_pkg::bus_req_s             req,
    output logic [periph_pkg::data_w-1:0]    rdata,
    output logic                             ack,
    input  logic [periph_pkg::data_w-1:0]    gpio_in,
    output logic [periph_pkg::data_w-1:0]    gpio_out,
    output logic [periph_pkg::data_w-1:0]    gpio_dir,
    input  logic [periph_pkg::n_ext_irq-1:0] ext_irq,
    input  logic                             irq_ack,
    input  logic                             irq_exit,
    output logic                             cpu_irq
);

    periph_pkg::reg_wr_s           wr;
    logic [periph_pkg::data_w-1:0] wdata;
    periph_pkg::timer_stat_s       tstat;
    periph_pkg::irq_stat_s         istat;
    logic [periph_pkg::data_w-1:0] gpio_data;
    logic [periph_pkg::data_w-1:0] gpio_dir_reg;
    logic                          timer_irq;

    periph_bus u_bus (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .wr        (wr),
        .wdata     (wdata),
        .tstat     (tstat),
        .gpio_data (gpio_data),
        .gpio_dir  (gpio_dir_reg),
        .istat     (istat),
        .rdata     (rdata),
        .ack       (ack)
    );

    sys_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .wdata     (wdata),
        .tstat     (tstat),
        .timer_irq (timer_irq)
    );

    gpio_port u_gpio (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .wdata    (wdata),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_dir (gpio_dir),
        .data     (gpio_data),
        .dir_reg  (gpio_dir_reg)
    );

    irq_controller u_irq (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .wdata     (wdata),
        .ext_irq   (ext_irq),
        .timer_irq (timer_irq),
        .irq_ack   (irq_ack),
        .irq_exit  (irq_exit),
        .cpu_irq   (cpu_irq),
        .istat     (istat)
    );

endmodule

// ==== periph_properties.sv ====
`timescale 1ns/100ps

module periph_properties (
    input logic                 clk,
    input logic                 rst,
    input periph_pkg::bus_req_s req,
    input logic                 ack,
    input logic                 cpu_irq,
    input logic                 in_service
);

    // ack is last cycle's stb, gated by the current cyc
    ack_follows_stb: assert property (@(posedge clk) disable iff (rst)
        ack == (req.cyc && $past(req.stb)))
        else $error("ack is not a one cycle copy of stb under cyc");

    irq_not_in_service: assert property (@(posedge clk) disable iff (rst)
        !(cpu_irq && in_service))
        else $error("cpu_irq high while in_service is set");

    irq_low_after_reset: assert property (@(posedge clk)
        rst |=> !cpu_irq)
        else $error("cpu_irq high right after reset");

endmodule

bind periph_top periph_properties props (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .ack        (ack),
    .cpu_irq    (cpu_irq),
    .in_service (istat.in_service)
);

// ==== tb_periph.sv ====
`timescale 1ns/100ps

module tb_periph;

    localparam int ack_limit   = 8;
    localparam int irq_limit   = 16;
    localparam int drain_limit = 8;

    typedef struct packed {
        logic [31:0] got;
        logic [31:0] exp;
        logic [7:0]  tol;
    } chk_s;

    // expected register file contents
    typedef struct packed {
        logic [31:0] gpio_data;
        logic [31:0] gpio_dir;
        logic [63:0] counter_sample;
        logic [31:0] timer_value;
        logic [31:0] timer_max;
        logic        timer_ie;
        logic        timer_flag;
        logic        in_service;
        logic [3:0]  irq_num;
    } model_s;

    logic                 clk;
    logic                 rst;
    periph_pkg::bus_req_s req;
    logic [31:0]          rdata;
    logic                 ack;
    logic [31:0]          gpio_in;
    logic [31:0]          gpio_out;
    logic [31:0]          gpio_dir;
    logic [7:0]           ext_irq;
    logic                 irq_ack;
    logic                 irq_exit;
    logic                 cpu_irq;

    model_s model;
    chk_s   chk_q[$];
    string  msg_q[$];
    int     errors;
    int     checks;
    int     err_mark;

    periph_top dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rdata    (rdata),
        .ack      (ack),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_dir (gpio_dir),
        .ext_irq  (ext_irq),
        .irq_ack  (irq_ack),
        .irq_exit (irq_exit),
        .cpu_irq  (cpu_irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] lane_merge(logic [31:0] old_w, logic [31:0] new_w,
                                               logic [3:0] sel);
        logic [31:0] r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                r[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic model_s apply_write(model_s m, logic [3:0] idx, logic [3:0] sel,
                                           logic [31:0] d);
        model_s r;
        r = m;
        case (idx)
            periph_pkg::reg_gpio_data: r.gpio_data = lane_merge(m.gpio_data, d, sel);
            periph_pkg::reg_gpio_dir:  r.gpio_dir = lane_merge(m.gpio_dir, d, sel);
            periph_pkg::reg_timer_max: r.timer_max = lane_merge(m.timer_max, d, sel);
            default: ;
        endcase
        // narrow registers and commands only see lane 0
        if (sel[0]) begin
            case (idx)
                periph_pkg::reg_counter_lo: if (d[1]) r.counter_sample = '0;
                periph_pkg::reg_irq_ctrl:   r.in_service = d[0];
                periph_pkg::reg_timer_ie:   r.timer_ie = d[0];
                periph_pkg::reg_timer_if:   if (d[0]) r.timer_flag = 1'b0;
                default: ;
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_read(model_s m, logic [3:0] idx);
        logic [31:0] r;
        case (idx)
            periph_pkg::reg_gpio_data:   r = m.gpio_data;
            periph_pkg::reg_gpio_dir:    r = m.gpio_dir;
            periph_pkg::reg_counter_lo:  r = m.counter_sample[31:0];
            periph_pkg::reg_counter_hi:  r = m.counter_sample[63:32];
            periph_pkg::reg_irq_ctrl:    r = {31'b0, m.in_service};
            periph_pkg::reg_timer_ie:    r = {31'b0, m.timer_ie};
            periph_pkg::reg_timer_if:    r = {31'b0, m.timer_flag};
            periph_pkg::reg_timer_value: r = m.timer_value;
            periph_pkg::reg_timer_max:   r = m.timer_max;
            periph_pkg::reg_irq_number:  r = {26'b0, m.irq_num, 2'b00};
            default:                     r = '0;
        endcase
        return r;
    endfunction

    // timer on top, then the highest external line
    function automatic logic [3:0] highest_source(logic [7:0] ext, logic timer);
        logic [3:0] r;
        logic       found;
        r = '0;
        found = timer;
        if (timer) begin
            r = 4'd8;
        end
        for (int i = 7; i >= 0; i--) begin
            if (!found && ext[i]) begin
                r = 4'(i);
                found = 1'b1;
            end
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare process

    function automatic void expect_word(string what, logic [31:0] got, logic [31:0] exp,
                                        int tol);
        chk_q.push_back('{got: got, exp: exp, tol: 8'(tol)});
        msg_q.push_back(what);
    endfunction

    initial begin
        chk_s   c;
        string  m;
        longint d;
        forever begin
            @(posedge clk);
            while (chk_q.size() > 0) begin
                c = chk_q.pop_front();
                m = msg_q.pop_front();
                d = longint'(c.got) - longint'(c.exp);
                checks++;
                assert (d <= longint'(c.tol) && d >= -longint'(c.tol)) else begin
                    $display("Error at %0t: %s, got %h expected %h", $time, m, c.got, c.exp);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus and pin tasks

    task automatic bus_access(input logic we, input logic [3:0] idx, input logic [3:0] sel,
                              input logic [31:0] data, output logic [31:0] rd);
        int n;
        @(negedge clk);
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: idx, sel: sel, wdata: data};
        for (n = 0; n < ack_limit; n++) begin
            @(negedge clk);
            if (ack) break;
        end
        rd = rdata;
        req = '0;
        if (n == ack_limit) begin
            $display("timeout: register %0d never acknowledged the bus access", idx);
            errors++;
        end else if (we) begin
            model = apply_write(model, idx, sel, data);
        end
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [3:0] sel,
                             input logic [31:0] data);
        logic [31:0] unused_rd;
        bus_access(1'b1, idx, sel, data, unused_rd);
    endtask

    task automatic read_check(input logic [3:0] idx, input string what, input int tol);
        logic [31:0] got;
        bus_access(1'b0, idx, 4'hf, '0, got);
        expect_word(what, got, ref_read(model, idx), tol);
    endtask

    task automatic wait_irq(input logic level, input string what);
        int n;
        for (n = 0; n < irq_limit; n++) begin
            if (cpu_irq == level) break;
            @(negedge clk);
        end
        if (n == irq_limit) begin
            $display("timeout: cpu_irq never reached %0d while %s", level, what);
            errors++;
        end
    endtask

    // one cycle pulse on irq_ack or irq_exit
    task automatic pulse_cpu_line(input logic exit_line);
        @(negedge clk);
        irq_ack = ~exit_line;
        irq_exit = exit_line;
        @(negedge clk);
        irq_ack = 1'b0;
        irq_exit = 1'b0;
    endtask

    task automatic end_test(input string name);
        int n;
        for (n = 0; n < drain_limit; n++) begin
            if (chk_q.size() == 0) break;
            @(negedge clk);
        end
        if (n == drain_limit) begin
            $display("compare process still held %0d checks after test %s", chk_q.size(), name);
            errors++;
        end
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - err_mark);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests

    task automatic test_registers();
        logic [31:0] d;
        logic [3:0]  sel;
        err_mark = errors;
        for (int k = 0; k < 8; k++) begin
            d = $urandom();
            sel = 4'($urandom_range(15, 1));
            write_reg(periph_pkg::reg_timer_max, sel, d);
            read_check(periph_pkg::reg_timer_max, "timer_max after byte write", 0);
            d = $urandom();
            sel = 4'($urandom_range(15, 1));
            write_reg(periph_pkg::reg_gpio_dir, sel, d);
            read_check(periph_pkg::reg_gpio_dir, "gpio_dir after byte write", 0);
        end
        for (int a = 10; a < 16; a++) begin
            read_check(4'(a), "unmapped register", 0);
        end
        end_test("register access");
    endtask

    task automatic test_counter();
        int idle;
        err_mark = errors;
        idle = 12;
        write_reg(periph_pkg::reg_counter_lo, 4'h1, 32'h2);
        repeat (idle) @(negedge clk);
        write_reg(periph_pkg::reg_counter_lo, 4'h1, 32'h1);
        // one more cycle for the sample write to reach the bus
        model.counter_sample = 64'(idle + 1);
        read_check(periph_pkg::reg_counter_lo, "sampled cycle count", 2);
        read_check(periph_pkg::reg_counter_hi, "sampled count high word", 0);
        end_test("cycle counter");
    endtask

    task automatic test_timer();
        int max_v;
        err_mark = errors;
        max_v = 5;
        write_reg(periph_pkg::reg_timer_max, 4'hf, 32'(max_v));
        write_reg(periph_pkg::reg_timer_if, 4'h1, 32'h3);
        read_check(periph_pkg::reg_timer_if, "flag after clear", 0);
        // second read lands max+2 cycles after the reload
        repeat (max_v - 2) @(negedge clk);
        model.timer_flag = 1'b1;
        read_check(periph_pkg::reg_timer_if, "flag after one timer period", 0);
        write_reg(periph_pkg::reg_timer_if, 4'h1, 32'h2);
        model.timer_value = 32'(max_v - 1);
        read_check(periph_pkg::reg_timer_value, "value after reload", 1);
        end_test("system timer");
    endtask

    task automatic test_gpio();
        logic [31:0] masks [4];
        logic [31:0] w;
        logic [31:0] v;
        err_mark = errors;
        masks[0] = 32'h0000_0000;
        masks[1] = 32'hffff_ffff;
        masks[2] = 32'h00ff_f0f0;
        masks[3] = $urandom();
        for (int k = 0; k < 4; k++) begin
            w = $urandom();
            v = $urandom();
            write_reg(periph_pkg::reg_gpio_dir, 4'hf, masks[k]);
            write_reg(periph_pkg::reg_gpio_data, 4'hf, w);
            gpio_in = v;
            repeat (4) @(negedge clk);
            expect_word("gpio_out output bits", gpio_out & ~masks[k], w & ~masks[k], 0);
            expect_word("gpio_dir pins", gpio_dir, masks[k], 0);
            model.gpio_data = (masks[k] & v) | (~masks[k] & w);
            read_check(periph_pkg::reg_gpio_data, "gpio_data with inputs", 0);
        end
        end_test("gpio");
    endtask

    task automatic test_interrupts();
        logic [7:0] ext;
        err_mark = errors;
        ext = 8'($urandom_range(255, 1));
        @(negedge clk);
        ext_irq = ext;
        wait_irq(1'b1, "external lines are active");
        model.irq_num = highest_source(ext, 1'b0);
        read_check(periph_pkg::reg_irq_number, "external source number", 0);
        pulse_cpu_line(1'b0);
        expect_word("cpu_irq after ack", 32'(cpu_irq), 32'h0, 0);
        model.in_service = 1'b1;
        read_check(periph_pkg::reg_irq_ctrl, "in_service after ack", 0);
        ext_irq = '0;
        pulse_cpu_line(1'b1);
        model.in_service = 1'b0;
        read_check(periph_pkg::reg_irq_ctrl, "in_service after exit", 0);

        // timer flag is still set from the timer test
        write_reg(periph_pkg::reg_timer_ie, 4'h1, 32'h1);
        wait_irq(1'b1, "the timer flag is enabled");
        model.irq_num = highest_source(8'h00, 1'b1);
        read_check(periph_pkg::reg_irq_number, "timer source number", 0);
        pulse_cpu_line(1'b0);
        write_reg(periph_pkg::reg_timer_ie, 4'h1, 32'h0);
        pulse_cpu_line(1'b1);
        // a still enabled timer would latch again within these cycles
        repeat (2) @(negedge clk);
        expect_word("cpu_irq after timer exit", 32'(cpu_irq), 32'h0, 0);
        end_test("interrupts");
    endtask

    initial begin
        void'($urandom(82));
        rst = 1'b1;
        req = '0;
        gpio_in = '0;
        ext_irq = '0;
        irq_ack = 1'b0;
        irq_exit = 1'b0;
        model = '0;
        errors = 0;
        checks = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        test_registers();
        test_counter();
        test_timer();
        test_gpio();
        test_interrupts();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
periph_pkg.sv
periph_bus.sv
sys_timer.sv
gpio_port.sv
irq_controller.sv
periph_top.sv
periph_properties.sv
tb_periph.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := src.f
TOP        := tb_periph
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
